/* src/bulk_endp_pkg.sv */
`default_nettype none

package bulk_endp_pkg;

   // Largest bulk packet in each direction
   localparam int IN_MAX_PACKET = 8;
   localparam int OUT_MAX_PACKET = 8;

   // One spare slot tells a full ring apart from an empty one
   localparam int IN_DEPTH = IN_MAX_PACKET + 1;
   localparam int OUT_DEPTH = OUT_MAX_PACKET + 1;

   // Clocks per full-speed bit, also the application byte spacing
   localparam int BIT_SAMPLES = 4;

   typedef logic [7:0] byte_t;

   // OUT data and handshake strobe coming from the SIE
   typedef struct packed {
      byte_t data;
      logic  valid;
      logic  err;
      logic  ready;
   } sie_out_t;

   // IN transaction request and consume strobe from the SIE
   typedef struct packed {
      logic req;
      logic ready;
   } sie_in_req_t;

   // IN data handed to the SIE
   typedef struct packed {
      byte_t data;
      logic  valid;
   } sie_in_tx_t;

   // One application byte with its valid
   typedef struct packed {
      byte_t data;
      logic  valid;
   } app_stream_t;

endpackage

`default_nettype wire

/* src/byte_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ring
   import bulk_endp_pkg::*;
#(
   parameter int DEPTH = IN_DEPTH
) (
   input  wire logic                     clk_i,
   input  wire logic                     rstn,
   input  wire logic                     wr_en_i,
   input  wire logic [$clog2(DEPTH)-1:0] wr_ptr_i,
   input  wire byte_t                    wr_data_i,
   input  wire logic [$clog2(DEPTH)-1:0] rd_ptr_i,
   output byte_t                         rd_data_o
);

   byte_t mem_q [DEPTH];

   // Every slot starts at zero after reset
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         mem_q[wr_ptr_i] <= wr_data_i;
      end
   end

   // The owner picks which slot is read
   assign rd_data_o = mem_q[rd_ptr_i];

   // The endpoint wraps its pointers before they reach DEPTH
   a_wr_ptr_range: assert property (
      @(posedge clk_i) disable iff (!rstn)
      wr_ptr_i < DEPTH
   );

endmodule

`default_nettype wire

/* src/in_endp.sv */
`timescale 1ns/1ps
`default_nettype none

module in_endp
   import bulk_endp_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rstn,
   input  wire app_stream_t app_in_i,
   output logic             app_in_ready_o,
   input  wire sie_in_req_t sie_in_req_i,
   input  wire logic        sie_out_valid_i,
   input  wire logic        sie_out_ready_i,
   output sie_in_tx_t       sie_in_o
);

   localparam int PTR_W = $clog2(IN_DEPTH);
   localparam int CNT_W = $clog2(BIT_SAMPLES);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   localparam ptr_t PTR_LAST = ptr_t'(IN_DEPTH - 1);
   localparam cnt_t CNT_MAX = cnt_t'(BIT_SAMPLES - 1);

   ptr_t  wr_ptr_q;
   ptr_t  cmt_ptr_q;
   ptr_t  rd_ptr_q;
   logic  pend_q;
   logic  req_q;
   logic  valid_q;
   cnt_t  cnt_q;
   logic  full;
   logic  app_acc;
   logic  in_start;
   logic  tx_adv;
   byte_t rd_data;

   function automatic ptr_t inc(input ptr_t p);
      return (p == PTR_LAST) ? '0 : p + 1'b1;
   endfunction

   // Space is freed only by committed reads, so replayed bytes stay put
   assign full = (inc(wr_ptr_q) == cmt_ptr_q);
   assign app_in_ready_o = (cnt_q == CNT_MAX) && !full;
   assign app_acc = app_in_i.valid && app_in_ready_o;

   // The application gets at most one byte in per pacing interval
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         wr_ptr_q <= '0;
         cnt_q <= '0;
      end else if (cnt_q != CNT_MAX) begin
         cnt_q <= cnt_q + 1'b1;
      end else if (app_acc) begin
         cnt_q <= '0;
         wr_ptr_q <= inc(wr_ptr_q);
      end
   end

   byte_ring #(
      .DEPTH(IN_DEPTH)
   ) u_ring (
      .clk_i,
      .rstn,
      .wr_en_i  (app_acc),
      .wr_ptr_i (wr_ptr_q),
      .wr_data_i(app_in_i.data),
      .rd_ptr_i (rd_ptr_q),
      .rd_data_o(rd_data)
   );

   assign in_start = sie_in_req_i.req && !req_q;

   // Never step past the last written byte, even in the cycle valid lags
   assign tx_adv = sie_in_req_i.req && req_q && sie_in_req_i.ready && valid_q &&
                   (rd_ptr_q != wr_ptr_q);

   // The SIE read position rewinds on every new request and is committed on the host ACK
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         req_q <= 1'b0;
         rd_ptr_q <= '0;
         cmt_ptr_q <= '0;
         pend_q <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         req_q <= sie_in_req_i.req;

         if (in_start) begin
            rd_ptr_q <= cmt_ptr_q;
            pend_q <= 1'b1;
         end else if (tx_adv) begin
            rd_ptr_q <= inc(rd_ptr_q);
         end

         // The first strobe after the transaction decides the outcome
         // A data strobe means the host went on to an OUT, so no ACK came
         if (!sie_in_req_i.req && sie_out_ready_i) begin
            pend_q <= 1'b0;
            if (pend_q && !sie_out_valid_i) begin
               cmt_ptr_q <= rd_ptr_q;
            end
         end

         if (!sie_in_req_i.req) begin
            valid_q <= 1'b0;
         end else if (in_start) begin
            valid_q <= (cmt_ptr_q != wr_ptr_q);
         end else if (rd_ptr_q == wr_ptr_q) begin
            valid_q <= 1'b0;
         end
      end
   end

   assign sie_in_o = '{data: rd_data, valid: valid_q};

   // An accepted byte never lands on the oldest unacknowledged byte
   a_no_write_when_full: assert property (
      @(posedge clk_i) disable iff (!rstn)
      app_acc |=> (wr_ptr_q != cmt_ptr_q)
   );

endmodule

`default_nettype wire

/* src/out_endp.sv */
`timescale 1ns/1ps
`default_nettype none

module out_endp
   import bulk_endp_pkg::*;
(
   input  wire logic     clk_i,
   input  wire logic     rstn,
   input  wire sie_out_t sie_out_i,
   output logic          out_nak_o,
   output app_stream_t   app_out_o,
   input  wire logic     app_out_ready_i
);

   localparam int PTR_W = $clog2(OUT_DEPTH);
   localparam int CNT_W = $clog2(BIT_SAMPLES);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   localparam ptr_t PTR_LAST = ptr_t'(OUT_DEPTH - 1);
   localparam cnt_t CNT_MAX = cnt_t'(BIT_SAMPLES - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DATA,
      ST_NAK
   } state_t;

   state_t state_q;
   ptr_t   cmt_wr_q;
   ptr_t   tr_wr_q;
   ptr_t   rd_ptr_q;
   logic   nak_q;
   logic   full_q;
   cnt_t   cnt_q;
   logic   strobe_err;
   logic   strobe_end;
   logic   strobe_byte;
   logic   byte_acc;
   logic   empty;
   logic   out_valid;
   logic   app_take;
   byte_t  rd_data;

   function automatic ptr_t inc(input ptr_t p);
      return (p == PTR_LAST) ? '0 : p + 1'b1;
   endfunction

   assign strobe_err = sie_out_i.ready && sie_out_i.err;
   assign strobe_end = sie_out_i.ready && !sie_out_i.err && !sie_out_i.valid;
   assign strobe_byte = sie_out_i.ready && !sie_out_i.err && sie_out_i.valid;

   // Once a packet has overflowed, the rest of it is refused too
   assign byte_acc = strobe_byte && !full_q && (state_q != ST_NAK);

   // SIE bytes go in at the transaction pointer
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q <= ST_IDLE;
         cmt_wr_q <= '0;
         tr_wr_q <= '0;
         nak_q <= 1'b0;
      end else if (strobe_err) begin
         state_q <= ST_IDLE;
         tr_wr_q <= cmt_wr_q;
         nak_q <= 1'b0;
      end else if (strobe_end) begin
         state_q <= ST_IDLE;
         // A NAKed packet is incomplete, so it is dropped
         if (nak_q) begin
            tr_wr_q <= cmt_wr_q;
         end else begin
            cmt_wr_q <= tr_wr_q;
         end
      end else if (strobe_byte) begin
         if (byte_acc) begin
            state_q <= ST_DATA;
            tr_wr_q <= inc(tr_wr_q);
            nak_q <= 1'b0;
         end else begin
            state_q <= ST_NAK;
            nak_q <= 1'b1;
         end
      end
   end

   byte_ring #(
      .DEPTH(OUT_DEPTH)
   ) u_ring (
      .clk_i,
      .rstn,
      .wr_en_i  (byte_acc),
      .wr_ptr_i (tr_wr_q),
      .wr_data_i(sie_out_i.data),
      .rd_ptr_i (rd_ptr_q),
      .rd_data_o(rd_data)
   );

   // The application only sees what has been committed
   assign empty = (rd_ptr_q == cmt_wr_q);
   assign out_valid = !empty && (cnt_q == CNT_MAX);
   assign app_take = out_valid && app_out_ready_i;

   // The application read side also samples the full status while the counter waits
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         rd_ptr_q <= '0;
         cnt_q <= '0;
         full_q <= 1'b0;
      end else if (cnt_q != CNT_MAX) begin
         cnt_q <= cnt_q + 1'b1;
      end else begin
         full_q <= (inc(tr_wr_q) == rd_ptr_q);
         if (app_take) begin
            cnt_q <= '0;
            rd_ptr_q <= inc(rd_ptr_q);
         end
      end
   end

   assign app_out_o = '{data: rd_data, valid: out_valid};
   assign out_nak_o = nak_q;

   // Valid comes up only over bytes already committed or just committed
   a_valid_after_commit: assert property (
      @(posedge clk_i) disable iff (!rstn)
      $rose(out_valid) |-> $past((cmt_wr_q != rd_ptr_q) || (strobe_end && !nak_q))
   );

endmodule

`default_nettype wire

/* src/bulk_endp.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_endp
   import bulk_endp_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rstn,
   input  wire logic        usb_reset_i,

   // Application
   input  wire app_stream_t app_in_i,
   output logic             app_in_ready_o,
   output app_stream_t      app_out_o,
   input  wire logic        app_out_ready_i,

   // SIE
   input  wire sie_in_req_t sie_in_req_i,
   output sie_in_tx_t       sie_in_o,
   input  wire sie_out_t    sie_out_i,
   output logic             out_nak_o
);

   logic endp_rstn;

   // A bus reset from the host clears both endpoints like a power-on reset
   assign endp_rstn = rstn && !usb_reset_i;

   // The IN side watches the OUT strobes to catch the host ACK
   in_endp u_in_endp (
      .clk_i,
      .rstn           (endp_rstn),
      .app_in_i,
      .app_in_ready_o,
      .sie_in_req_i,
      .sie_out_valid_i(sie_out_i.valid),
      .sie_out_ready_i(sie_out_i.ready),
      .sie_in_o
   );

   out_endp u_out_endp (
      .clk_i,
      .rstn           (endp_rstn),
      .sie_out_i,
      .out_nak_o,
      .app_out_o,
      .app_out_ready_i
   );

endmodule

`default_nettype wire

/* tests/bulk_endp_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_endp_checker
   import bulk_endp_pkg::*;
(
   input wire logic        clk_i,
   input wire logic        rstn,
   input wire logic        usb_reset_i,
   input wire app_stream_t app_in_i,
   input wire logic        app_in_ready_i,
   input wire app_stream_t app_out_i,
   input wire logic        app_out_ready_i,
   input wire sie_in_req_t sie_in_req_i,
   input wire sie_in_tx_t  sie_in_i,
   input wire sie_out_t    sie_out_i,
   input wire logic        out_nak_i
);

   int errors = 0;

   // Bytes not yet acknowledged on the IN side and the read position inside a transaction
   byte_t in_q[$];
   int    in_idx;
   logic  in_pend;
   logic  req_prev;
   int    in_wait;

   // Committed OUT bytes, the packet in flight and the NAK state
   byte_t out_q[$];
   byte_t pkt_q[$];
   logic  nak;
   logic  nak_state;
   logic  full;
   int    out_wait;

   logic exp_ready;
   logic exp_valid;
   logic full_next;

   task automatic report_mismatch(input string msg);
      errors++;
      $display("mismatch at %0t: %s", $time, msg);
   endtask

   task automatic clear_model();
      in_q.delete();
      pkt_q.delete();
      out_q.delete();
      in_idx = 0;
      in_pend = 1'b0;
      req_prev = 1'b0;
      in_wait = 0;
      nak = 1'b0;
      nak_state = 1'b0;
      full = 1'b0;
      out_wait = 0;
   endtask

   // DUT registers update with nonblocking writes, so values read here are pre-edge
   always @(posedge clk_i) begin
      if (!rstn || usb_reset_i) begin
         if (app_in_ready_i || app_out_i.valid || sie_in_i.valid || out_nak_i) begin
            report_mismatch("an output is high during reset");
         end
         clear_model();
      end else begin
         exp_ready = (in_wait == BIT_SAMPLES - 1) && (in_q.size() < IN_DEPTH - 1);
         if (app_in_ready_i != exp_ready) begin
            report_mismatch($sformatf("app_in_ready_o is %0b, expected %0b",
                                      app_in_ready_i, exp_ready));
         end
         if (sie_in_req_i.req && req_prev && sie_in_req_i.ready && sie_in_i.valid) begin
            if (in_idx >= in_q.size()) begin
               report_mismatch("IN data valid past the last written byte");
            end else begin
               if (sie_in_i.data != in_q[in_idx]) begin
                  report_mismatch($sformatf("IN byte %0d is %02h, expected %02h",
                                            in_idx, sie_in_i.data, in_q[in_idx]));
               end
               in_idx++;
            end
         end
         // The first strobe after the request ends decides whether to commit
         if (!sie_in_req_i.req && sie_out_i.ready) begin
            if (in_pend && !sie_out_i.valid) begin
               for (int i = 0; i < in_idx; i++) begin
                  in_q.delete(0);
               end
            end
            in_pend = 1'b0;
         end
         if (sie_in_req_i.req && !req_prev) begin
            in_idx = 0;
            in_pend = 1'b1;
         end
         if (app_in_i.valid && app_in_ready_i) begin
            in_q.push_back(app_in_i.data);
            in_wait = 0;
         end else if (in_wait < BIT_SAMPLES - 1) begin
            in_wait++;
         end
         req_prev = sie_in_req_i.req;

         exp_valid = (out_q.size() > 0) && (out_wait == BIT_SAMPLES - 1);
         if (app_out_i.valid != exp_valid) begin
            report_mismatch($sformatf("app_out_o.valid is %0b, expected %0b",
                                      app_out_i.valid, exp_valid));
         end else if (exp_valid && app_out_i.data != out_q[0]) begin
            report_mismatch($sformatf("OUT byte is %02h, expected %02h",
                                      app_out_i.data, out_q[0]));
         end
         if (out_nak_i != nak) begin
            report_mismatch($sformatf("out_nak_o is %0b, expected %0b", out_nak_i, nak));
         end
         // Full counts bytes of the packet in flight too, and lags by one clock
         full_next = full;
         if (out_wait == BIT_SAMPLES - 1) begin
            full_next = (out_q.size() + pkt_q.size() == OUT_DEPTH - 1);
         end
         if (exp_valid && app_out_ready_i) begin
            out_q.delete(0);
            out_wait = 0;
         end else if (out_wait < BIT_SAMPLES - 1) begin
            out_wait++;
         end
         if (sie_out_i.ready) begin
            if (sie_out_i.err) begin
               pkt_q.delete();
               nak = 1'b0;
               nak_state = 1'b0;
            end else if (!sie_out_i.valid) begin
               if (!nak) begin
                  foreach (pkt_q[i]) begin
                     out_q.push_back(pkt_q[i]);
                  end
               end
               pkt_q.delete();
               nak_state = 1'b0;
            end else if (!full && !nak_state) begin
               pkt_q.push_back(sie_out_i.data);
               nak = 1'b0;
               nak_state = 1'b0;
            end else begin
               nak = 1'b1;
               nak_state = 1'b1;
            end
         end
         full = full_next;
      end
   end

endmodule

`default_nettype wire

/* tests/tb_bulk_endp.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bulk_endp
   import bulk_endp_pkg::*;
();

   typedef enum logic [2:0] {
      OP_APP_WR,
      OP_IN_ACK,
      OP_IN_NOACK,
      OP_OUT,
      OP_OUT_ERR,
      OP_USB_RST
   } op_t;

   // Each row holds an operation, a byte count, an application stall flag and the expected out_nak_o
   typedef struct packed {
      op_t  op;
      int   count;
      logic stall;
      logic nak;
   } row_t;

   localparam int NUM_ROWS = 17;
   localparam int RESET_CYCLES = 16;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * 200 + RESET_CYCLES;
   localparam logic [31:0] SEED = 32'h3ebf3e7c;

   localparam row_t ROWS [NUM_ROWS] = '{
      '{OP_USB_RST, 0, 1'b0, 1'b0},
      '{OP_APP_WR, 5, 1'b0, 1'b0},
      '{OP_IN_NOACK, 5, 1'b0, 1'b0},
      '{OP_IN_ACK, 5, 1'b0, 1'b0},
      '{OP_APP_WR, 8, 1'b0, 1'b0},
      '{OP_IN_NOACK, 8, 1'b0, 1'b0},
      '{OP_OUT, 4, 1'b0, 1'b0},
      '{OP_IN_ACK, 8, 1'b0, 1'b0},
      '{OP_OUT_ERR, 3, 1'b0, 1'b0},
      '{OP_OUT, 6, 1'b0, 1'b0},
      '{OP_OUT, 12, 1'b1, 1'b1},
      '{OP_OUT, 3, 1'b0, 1'b0},
      '{OP_APP_WR, 3, 1'b0, 1'b0},
      '{OP_USB_RST, 0, 1'b0, 1'b0},
      '{OP_APP_WR, 2, 1'b0, 1'b0},
      '{OP_IN_ACK, 2, 1'b0, 1'b0},
      '{OP_OUT, 8, 1'b0, 1'b0}
   };

   logic        clk_i;
   logic        rstn;
   logic        usb_reset_i;
   app_stream_t app_in_i;
   logic        app_in_ready_o;
   app_stream_t app_out_o;
   logic        app_out_ready_i;
   sie_in_req_t sie_in_req_i;
   sie_in_tx_t  sie_in_o;
   sie_out_t    sie_out_i;
   logic        out_nak_o;
   logic        stall_app;
   int          tb_errors;
   int          cycles = 0;

   bulk_endp u_dut (
      .clk_i, .rstn, .usb_reset_i, .app_in_i, .app_in_ready_o, .app_out_o,
      .app_out_ready_i, .sie_in_req_i, .sie_in_o, .sie_out_i, .out_nak_o
   );

   bulk_endp_checker u_checker (
      .clk_i, .rstn, .usb_reset_i, .app_in_i, .app_in_ready_i(app_in_ready_o),
      .app_out_i(app_out_o), .app_out_ready_i, .sie_in_req_i, .sie_in_i(sie_in_o),
      .sie_out_i, .out_nak_i(out_nak_o)
   );

   always #2 clk_i = ~clk_i;

   // The application takes OUT bytes at random unless a row stalls it
   always @(negedge clk_i) begin
      app_out_ready_i <= stall_app ? 1'b0 : (($urandom % 2) == 1);
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         tb_errors++;
         $display("errors: %0d total", tb_errors + u_checker.errors);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   task automatic drive_app_bytes(input int n);
      int waited;
      for (int i = 0; i < n; i++) begin
         @(negedge clk_i);
         app_in_i = '{data: byte_t'($urandom), valid: 1'b1};
         waited = 0;
         @(posedge clk_i);
         while (!app_in_ready_o) begin
            waited++;
            if (waited > BIT_SAMPLES) begin
               $display("Error: app_in_ready_o stalled at byte %0d of %0d", i, n);
               tb_errors++;
               @(negedge clk_i);
               app_in_i = '0;
               return;
            end
            @(posedge clk_i);
         end
      end
      @(negedge clk_i);
      app_in_i = '0;
   endtask

   task automatic run_in_transaction(input int n, input logic ack);
      int sent;
      sent = 0;
      @(negedge clk_i);
      sie_in_req_i.req = 1'b1;
      wait_cycles(2);
      while (sie_in_o.valid && sent <= IN_DEPTH) begin
         sie_in_req_i.ready = 1'b1;
         @(negedge clk_i);
         sie_in_req_i.ready = 1'b0;
         sent++;
         wait_cycles(1 + $urandom % 3);
      end
      if (sent != n) begin
         $display("mismatch at %0t: IN transaction gave %0d bytes, expected %0d",
                  $time, sent, n);
         tb_errors++;
      end
      sie_in_req_i.req = 1'b0;
      wait_cycles(2);
      if (ack) begin
         sie_out_i = '{data: 8'h00, valid: 1'b0, err: 1'b0, ready: 1'b1};
         @(negedge clk_i);
         sie_out_i = '0;
         wait_cycles(2);
      end
   endtask

   task automatic wait_out_drain();
      int idle;
      int spent;
      idle = 0;
      spent = 0;
      while (idle < 2 * BIT_SAMPLES && spent < 150) begin
         @(negedge clk_i);
         spent++;
         idle = app_out_o.valid ? 0 : idle + 1;
      end
      if (spent >= 150) begin
         $display("Error: OUT data was not drained by the application");
         tb_errors++;
      end
   endtask

   task automatic send_out_packet(input int n, input logic ends_in_error);
      for (int i = 0; i < n; i++) begin
         wait_cycles(2 + $urandom % 3);
         sie_out_i = '{data: byte_t'($urandom), valid: 1'b1, err: 1'b0, ready: 1'b1};
         @(negedge clk_i);
         sie_out_i = '0;
      end
      wait_cycles(2 + $urandom % 3);
      sie_out_i = '{data: 8'h00, valid: ends_in_error, err: ends_in_error, ready: 1'b1};
      @(negedge clk_i);
      sie_out_i = '0;
      wait_cycles(2);
   endtask

   task automatic pulse_usb_reset();
      int waited;
      @(negedge clk_i);
      usb_reset_i = 1'b1;
      wait_cycles(4);
      usb_reset_i = 1'b0;
      waited = 0;
      @(posedge clk_i);
      while (!app_in_ready_o && waited <= BIT_SAMPLES) begin
         waited++;
         @(posedge clk_i);
      end
      if (!app_in_ready_o) begin
         $display("Error: app_in_ready_o did not rise after the usb reset");
         tb_errors++;
      end
   endtask

   initial begin
      clk_i = 1'b0;
      rstn = 1'b0;
      usb_reset_i = 1'b0;
      app_in_i = '0;
      app_out_ready_i = 1'b0;
      sie_in_req_i = '0;
      sie_out_i = '0;
      stall_app = 1'b0;
      tb_errors = 0;
      void'($urandom(SEED));
      wait_cycles(RESET_CYCLES);
      rstn = 1'b1;

      for (int r = 0; r < NUM_ROWS; r++) begin
         stall_app = ROWS[r].stall;
         case (ROWS[r].op)
            OP_APP_WR:   drive_app_bytes(ROWS[r].count);
            OP_IN_ACK:   run_in_transaction(ROWS[r].count, 1'b1);
            OP_IN_NOACK: run_in_transaction(ROWS[r].count, 1'b0);
            OP_OUT:      send_out_packet(ROWS[r].count, 1'b0);
            OP_OUT_ERR:  send_out_packet(ROWS[r].count, 1'b1);
            default:     pulse_usb_reset();
         endcase
         if (!ROWS[r].stall) begin
            wait_out_drain();
         end
         @(negedge clk_i);
         if (out_nak_o !== ROWS[r].nak) begin
            $display("mismatch at %0t: row %0d ends with out_nak_o %0b, expected %0b",
                     $time, r, out_nak_o, ROWS[r].nak);
            tb_errors++;
         end
         stall_app = 1'b0;
      end

      wait_cycles(4);
      $display("errors: %0d total, %0d from checker, %0d from testbench",
               tb_errors + u_checker.errors, u_checker.errors, tb_errors);
      if (tb_errors + u_checker.errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bulk_endp.f */
src/bulk_endp_pkg.sv
src/byte_ring.sv
src/in_endp.sv
src/out_endp.sv
src/bulk_endp.sv
tests/bulk_endp_checker.sv
tests/tb_bulk_endp.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_bulk_endp -f bulk_endp.f \
   --Mdir obj_dir -o sim_bulk_endp
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_bulk_endp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
   exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
   echo "Simulation log has no final result"
   exit 1
fi
exit 0
